//--- rtl/front_pkg.sv
package front_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int xlen        = 32;
    localparam int imem_words  = 256;
    localparam int imem_aw     = $clog2(imem_words);
    localparam int bht_entries = 64;
    localparam int bht_iw      = $clog2(bht_entries);

    localparam logic [xlen-1:0] reset_pc = '0;
    localparam string           rom_file = "prog.hex";

    ////////////////////
    // Branch opcodes
    ////////////////////

    // Major opcode in inst bits 31:26
    localparam logic [5:0] op_beqz = 6'h12;
    localparam logic [5:0] op_jirl = 6'h13;
    localparam logic [5:0] op_b    = 6'h14;
    localparam logic [5:0] op_bl   = 6'h15;
    localparam logic [5:0] op_beq  = 6'h16;
    localparam logic [5:0] op_bne  = 6'h17;
    localparam logic [5:0] op_blt  = 6'h18;
    localparam logic [5:0] op_bge  = 6'h19;
    localparam logic [5:0] op_bltu = 6'h1a;
    localparam logic [5:0] op_bgeu = 6'h1b;

    // Fetch address fault
    localparam logic [5:0] ecause_adef = 6'h08;

    typedef enum logic [1:0] {
        none,
        cond,
        uncond,
        indirect
    } br_kind_e;

    typedef struct packed {
        logic [xlen-1:0] pc_1;
        logic [xlen-1:0] pc_2;
        logic            is_exception;
        logic [5:0]      exception_cause;
    } pc_pair_t;

    typedef struct packed {
        br_kind_e        kind;
        logic [xlen-1:0] target;
    } br_info_t;

    // Resolved branch from the back end
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            taken;
    } bht_update_t;

    typedef struct packed {
        logic            valid_1;
        logic            valid_2;
        logic [xlen-1:0] pc_1;
        logic [xlen-1:0] pc_2;
        logic [xlen-1:0] inst_1;
        logic [xlen-1:0] inst_2;
        logic            is_branch_1;
        logic            is_branch_2;
        logic            pred_taken;
        logic [xlen-1:0] pred_target;
        logic            is_exception;
        logic [5:0]      exception_cause;
    } fetch_bundle_t;

endpackage

//--- rtl/pc_gen.sv
module pc_gen
    import front_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic [xlen-1:0] flush_pc_i,
    input  logic            redirect_i,
    input  logic [xlen-1:0] redirect_pc_i,
    output pc_pair_t        fetch_pc_o
);

    logic [xlen-1:0] pc_q;
    logic [xlen-1:0] pc_d;
    logic            fault_q;
    logic            fault_d;

    // Next PC, flush first, then predicted redirect, then hold or step
    always_comb begin
        pc_d    = pc_q;
        fault_d = fault_q;
        if (flush_i) begin
            pc_d    = {flush_pc_i[xlen-1:2], 2'b00};
            fault_d = |flush_pc_i[1:0];
        end else if (redirect_i) begin
            // Direct targets are word aligned
            pc_d    = redirect_pc_i;
            fault_d = 1'b0;
        end else if (!stall_i) begin
            // Fault pairs also step on from the aligned address
            pc_d    = pc_q + xlen'(8);
            fault_d = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q    <= reset_pc;
            fault_q <= 1'b0;
        end else begin
            pc_q    <= pc_d;
            fault_q <= fault_d;
        end
    end

    assign fetch_pc_o.pc_1            = pc_q;
    assign fetch_pc_o.pc_2            = pc_q + xlen'(4);
    assign fetch_pc_o.is_exception    = fault_q;
    assign fetch_pc_o.exception_cause = fault_q ? ecause_adef : 6'd0;

endmodule

//--- rtl/inst_rom.sv
module inst_rom
    import front_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  pc_pair_t        pc_i,
    output logic [xlen-1:0] inst_1_o,
    output logic [xlen-1:0] inst_2_o,
    output pc_pair_t        pc_o
);

    logic [xlen-1:0]    mem [imem_words];
    logic [imem_aw-1:0] addr_1;
    logic [imem_aw-1:0] addr_2;

    initial begin
        $readmemh(rom_file, mem);
    end

    // Word index, upper PC bits wrap
    assign addr_1 = pc_i.pc_1[imem_aw+1:2];
    assign addr_2 = pc_i.pc_2[imem_aw+1:2];

    // Both reads registered, PC pair delayed alongside
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            // Empty slot, opcode zero decodes as no branch
            inst_1_o          <= '0;
            inst_2_o          <= '0;
            pc_o.is_exception <= 1'b0;
        end else if (!stall_i) begin
            inst_1_o <= mem[addr_1];
            inst_2_o <= mem[addr_2];
            pc_o     <= pc_i;
        end
    end

endmodule

//--- rtl/branch_decode.sv
module branch_decode
    import front_pkg::*;
(
    input  logic [xlen-1:0] inst_i,
    input  logic [xlen-1:0] pc_i,
    output br_info_t        info_o
);

    logic [5:0]      opcode;
    logic [xlen-1:0] offs16;
    logic [xlen-1:0] offs26;

    assign opcode = inst_i[31:26];

    ////////////////////
    // Offsets
    ////////////////////

    // Conditional format, offs16 in bits 25:10
    assign offs16 = {{(xlen-18){inst_i[25]}}, inst_i[25:10], 2'b00};

    // B and BL, high part of offs26 sits in bits 9:0
    assign offs26 = {{(xlen-28){inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    ////////////////////
    // Classification
    ////////////////////

    always_comb begin
        case (opcode)
            op_beqz, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                info_o.kind   = cond;
                info_o.target = pc_i + offs16;
            end
            op_b, op_bl: begin
                info_o.kind   = uncond;
                info_o.target = pc_i + offs26;
            end
            op_jirl: begin
                // Target depends on a register, nothing to compute here
                info_o.kind   = indirect;
                info_o.target = '0;
            end
            default: begin
                info_o.kind   = none;
                info_o.target = '0;
            end
        endcase
    end

endmodule

//--- rtl/bht.sv
module bht
    import front_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic [xlen-1:0] rd_pc_1_i,
    input  logic [xlen-1:0] rd_pc_2_i,
    input  bht_update_t     update_i,
    output logic [1:0]      ctr_1_o,
    output logic [1:0]      ctr_2_o
);

    logic [1:0]        ctr_q [bht_entries];
    logic [bht_iw-1:0] rd_idx_1;
    logic [bht_iw-1:0] rd_idx_2;
    logic [bht_iw-1:0] wr_idx;
    logic [1:0]        wr_old;
    logic [1:0]        wr_new;

    // Indexed by word address bits above the byte offset
    assign rd_idx_1 = rd_pc_1_i[bht_iw+1:2];
    assign rd_idx_2 = rd_pc_2_i[bht_iw+1:2];
    assign wr_idx   = update_i.pc[bht_iw+1:2];

    assign ctr_1_o = ctr_q[rd_idx_1];
    assign ctr_2_o = ctr_q[rd_idx_2];

    assign wr_old = ctr_q[wr_idx];

    // Saturating step
    always_comb begin
        wr_new = wr_old;
        if (update_i.taken) begin
            if (wr_old != 2'b11) begin
                wr_new = wr_old + 2'd1;
            end
        end else if (wr_old != 2'b00) begin
            wr_new = wr_old - 2'd1;
        end
    end

    // Weakly not taken after reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < bht_entries; i++) begin
                ctr_q[i] <= 2'b01;
            end
        end else if (update_i.valid) begin
            ctr_q[wr_idx] <= wr_new;
        end
    end

endmodule

//--- rtl/bpu.sv
module bpu
    import front_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  pc_pair_t        pc_i,
    input  logic [xlen-1:0] inst_1_i,
    input  logic [xlen-1:0] inst_2_i,
    input  bht_update_t     bht_update_i,
    output logic            redirect_o,
    output logic [xlen-1:0] redirect_pc_o,
    output fetch_bundle_t   bundle_o
);

    br_info_t      info_1;
    br_info_t      info_2;
    br_kind_e      kind_1;
    br_kind_e      kind_2;
    logic [1:0]    ctr_1;
    logic [1:0]    ctr_2;
    logic          live_q;
    logic          take_1;
    logic          take_2;
    fetch_bundle_t bundle_d;

    branch_decode u_dec_1 (
        .inst_i (inst_1_i),
        .pc_i   (pc_i.pc_1),
        .info_o (info_1)
    );

    branch_decode u_dec_2 (
        .inst_i (inst_2_i),
        .pc_i   (pc_i.pc_2),
        .info_o (info_2)
    );

    bht u_bht (
        .clk       (clk),
        .reset_i   (reset_i),
        .rd_pc_1_i (pc_i.pc_1),
        .rd_pc_2_i (pc_i.pc_2),
        .update_i  (bht_update_i),
        .ctr_1_o   (ctr_1),
        .ctr_2_o   (ctr_2)
    );

    ////////////////////
    // Prediction
    ////////////////////

    // A faulting pair holds no real instructions
    assign kind_1 = pc_i.is_exception ? none : info_1.kind;
    assign kind_2 = pc_i.is_exception ? none : info_2.kind;

    // Slot 1 wins, slot 2 only counts when slot 1 falls through
    assign take_1 = live_q && (kind_1 == uncond || (kind_1 == cond && ctr_1[1]));
    assign take_2 = live_q && !take_1
                    && (kind_2 == uncond || (kind_2 == cond && ctr_2[1]));

    always_comb begin
        bundle_d.valid_1         = live_q;
        bundle_d.valid_2         = live_q && !take_1 && !pc_i.is_exception;
        bundle_d.pc_1            = pc_i.pc_1;
        bundle_d.pc_2            = pc_i.pc_2;
        bundle_d.inst_1          = inst_1_i;
        bundle_d.inst_2          = inst_2_i;
        bundle_d.is_branch_1     = live_q && (kind_1 != none);
        bundle_d.is_branch_2     = bundle_d.valid_2 && (kind_2 != none);
        bundle_d.pred_taken      = take_1 || take_2;
        bundle_d.is_exception    = live_q && pc_i.is_exception;
        bundle_d.exception_cause = pc_i.exception_cause;
        if (take_1) begin
            bundle_d.pred_target = info_1.target;
        end else if (take_2) begin
            bundle_d.pred_target = info_2.target;
        end else begin
            bundle_d.pred_target = '0;
        end
    end

    // Held back while decode stalls
    assign redirect_o    = bundle_d.pred_taken && !stall_i;
    assign redirect_pc_o = bundle_d.pred_target;

    ////////////////////
    // Registers
    ////////////////////

    // Memory output is part of the stream, cleared for the pair behind a redirect
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            live_q <= 1'b0;
        end else if (!stall_i) begin
            live_q <= !redirect_o;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            bundle_o.valid_1      <= 1'b0;
            bundle_o.valid_2      <= 1'b0;
            bundle_o.is_branch_1  <= 1'b0;
            bundle_o.is_branch_2  <= 1'b0;
            bundle_o.pred_taken   <= 1'b0;
            bundle_o.is_exception <= 1'b0;
        end else if (!stall_i) begin
            bundle_o <= bundle_d;
        end
    end

endmodule

//--- rtl/fetch_frontend.sv
module fetch_frontend
    import front_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            flush_i,
    input  logic [xlen-1:0] flush_pc_i,
    input  bht_update_t     bht_update_i,
    output fetch_bundle_t   fetch_o
);

    pc_pair_t        fetch_pc;
    pc_pair_t        rom_pc;
    logic [xlen-1:0] inst_1;
    logic [xlen-1:0] inst_2;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;

    // PC stage
    pc_gen u_pc_gen (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .flush_pc_i    (flush_pc_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .fetch_pc_o    (fetch_pc)
    );

    // Memory stage
    inst_rom u_inst_rom (
        .clk      (clk),
        .reset_i  (reset_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .pc_i     (fetch_pc),
        .inst_1_o (inst_1),
        .inst_2_o (inst_2),
        .pc_o     (rom_pc)
    );

    // Prediction and bundle register
    bpu u_bpu (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .pc_i          (rom_pc),
        .inst_1_i      (inst_1),
        .inst_2_i      (inst_2),
        .bht_update_i  (bht_update_i),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .bundle_o      (fetch_o)
    );

endmodule

//--- sim/tb_fetch_frontend.sv
module tb_fetch_frontend
    import front_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int half_period = 50;
    localparam int max_cycles  = 2000;

    logic            clk;
    logic            reset;
    logic            stall;
    logic            flush;
    logic [xlen-1:0] flush_pc;
    bht_update_t     bht_update;
    fetch_bundle_t   fetch_bundle;

    // Program image and model counters
    logic [xlen-1:0] prog [imem_words];
    logic [1:0]      model_ctr [bht_entries];

    fetch_bundle_t   want;
    logic [xlen-1:0] exp_pc;
    logic            exp_fault;
    logic [xlen-1:0] last_pc;
    logic [xlen-1:0] base_trace [$];
    logic [xlen-1:0] stall_trace [$];
    int              recording;
    int              bundle_count;
    int              cycles;
    int              test_errors;
    int              total_errors;
    int              tests_run;
    int              tests_failed;
    int              seed;
    logic            stall_random;
    string           test_name;

    fetch_frontend uut (
        .clk          (clk),
        .reset_i      (reset),
        .stall_i      (stall),
        .flush_i      (flush),
        .flush_pc_i   (flush_pc),
        .bht_update_i (bht_update),
        .fetch_o      (fetch_bundle)
    );

    ////////////////////
    // Reference model
    ////////////////////

    function automatic br_kind_e classify(input logic [xlen-1:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op < op_beqz || op > op_bgeu) begin
            return none;
        end
        if (op == op_jirl) begin
            return indirect;
        end
        if (op == op_b || op == op_bl) begin
            return uncond;
        end
        return cond;
    endfunction

    function automatic logic [xlen-1:0] direct_target(input logic [xlen-1:0] w,
                                                      input logic [xlen-1:0] pc);
        logic signed [xlen-1:0] words;
        if (classify(w) == uncond) begin
            words = $signed({w[9:0], w[25:10]});
        end else begin
            words = $signed(w[25:10]);
        end
        return pc + words * 4;
    endfunction

    function automatic logic slot_taken(input logic [xlen-1:0] w, input logic [xlen-1:0] pc);
        if (classify(w) == uncond) begin
            return 1'b1;
        end
        return classify(w) == cond && model_ctr[pc[7:2]] >= 2'd2;
    endfunction

    // Bundle that decode should see for the pair at pc
    function automatic fetch_bundle_t expect_bundle(input logic [xlen-1:0] pc,
                                                    input logic fault);
        fetch_bundle_t   b;
        logic [xlen-1:0] pc2;
        pc2       = pc + 4;
        b         = '0;
        b.valid_1 = 1'b1;
        b.pc_1    = pc;
        b.pc_2    = pc2;
        b.inst_1  = prog[pc[9:2]];
        b.inst_2  = prog[pc2[9:2]];
        if (fault) begin
            b.is_exception    = 1'b1;
            b.exception_cause = ecause_adef;
            return b;
        end
        b.is_branch_1 = classify(b.inst_1) != none;
        if (slot_taken(b.inst_1, pc)) begin
            b.pred_taken  = 1'b1;
            b.pred_target = direct_target(b.inst_1, pc);
        end else begin
            b.valid_2     = 1'b1;
            b.is_branch_2 = classify(b.inst_2) != none;
            if (slot_taken(b.inst_2, pc2)) begin
                b.pred_taken  = 1'b1;
                b.pred_target = direct_target(b.inst_2, pc2);
            end
        end
        return b;
    endfunction

    ////////////////////
    // Clock, stall, timeout
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    always @(negedge clk) begin
        if (stall_random) begin
            stall = ($random(seed) & 1) == 1;
        end else begin
            stall = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: fetch did not reach the awaited PC within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // A bundle is taken by decode at an edge where stall is low
    always @(posedge clk) begin
        if (reset) begin
            exp_pc    = '0;
            exp_fault = 1'b0;
        end else begin
            if (!stall && fetch_bundle.valid_1) begin
                want = expect_bundle(exp_pc, exp_fault);
                if (fetch_bundle !== want) begin
                    $display("Fail %s: bundle for pc %h expected %h actual %h",
                             test_name, exp_pc, want, fetch_bundle);
                    test_errors = test_errors + 1;
                end
                bundle_count = bundle_count + 1;
                last_pc      = fetch_bundle.pc_1;
                if (recording == 1) begin
                    base_trace.push_back(fetch_bundle.pc_1);
                end else if (recording == 2) begin
                    stall_trace.push_back(fetch_bundle.pc_1);
                end
                exp_pc    = want.pred_taken ? want.pred_target : exp_pc + 8;
                exp_fault = 1'b0;
            end
            if (flush) begin
                exp_pc    = {flush_pc[xlen-1:2], 2'b00};
                exp_fault = |flush_pc[1:0];
            end
        end
    end

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic flush_to(input logic [xlen-1:0] addr);
        @(negedge clk);
        flush    = 1'b1;
        flush_pc = addr;
        @(negedge clk);
        flush    = 1'b0;
    endtask

    // Resolved branch from the back end, mirrored into the model table
    task automatic train(input logic [xlen-1:0] addr, input logic taken);
        @(negedge clk);
        bht_update.valid = 1'b1;
        bht_update.pc    = addr;
        bht_update.taken = taken;
        if (taken && model_ctr[addr[7:2]] != 2'd3) begin
            model_ctr[addr[7:2]] = model_ctr[addr[7:2]] + 2'd1;
        end else if (!taken && model_ctr[addr[7:2]] != 2'd0) begin
            model_ctr[addr[7:2]] = model_ctr[addr[7:2]] - 2'd1;
        end
        @(negedge clk);
        bht_update.valid = 1'b0;
    endtask

    task automatic wait_for_pc(input logic [xlen-1:0] addr);
        int start;
        start = bundle_count;
        @(negedge clk);
        while (bundle_count == start || last_pc != addr) begin
            @(negedge clk);
        end
    endtask

    task automatic report_test();
        $display("Test %-12s done, %0d mismatches", test_name, test_errors);
        tests_run = tests_run + 1;
        if (test_errors != 0) begin
            tests_failed = tests_failed + 1;
        end
        total_errors = total_errors + test_errors;
        test_errors  = 0;
    endtask

    initial begin
        reset        = 1'b1;
        stall        = 1'b0;
        flush        = 1'b0;
        flush_pc     = '0;
        bht_update   = '0;
        seed         = 32'h1c70087e;
        stall_random = 1'b0;
        recording    = 1;
        bundle_count = 0;
        cycles       = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        last_pc      = '0;
        test_name    = "sequential";
        $readmemh("prog.hex", prog);
        for (int i = 0; i < bht_entries; i++) begin
            model_ctr[i] = 2'b01;
        end
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Straight-line code up to the first B
        wait_for_pc(32'h20);
        report_test();

        test_name = "branches";
        wait_for_pc(32'hf0);
        recording = 0;
        report_test();

        // BNE at 0xa0 jumps back to 0x80 once trained
        test_name = "training";
        flush_to(32'h98);
        wait_for_pc(32'ha8);
        wait_for_pc(32'hf0);
        train(32'ha0, 1'b1);
        train(32'ha0, 1'b1);
        flush_to(32'h98);
        wait_for_pc(32'h80);
        wait_for_pc(32'hf0);
        train(32'ha0, 1'b0);
        train(32'ha0, 1'b0);
        flush_to(32'h98);
        wait_for_pc(32'ha8);
        wait_for_pc(32'hf0);
        report_test();

        test_name = "flush_fault";
        flush_to(32'h10);
        wait_for_pc(32'h20);
        wait_for_pc(32'hf0);
        flush_to(32'hc2);
        wait_for_pc(32'hc0);
        wait_for_pc(32'hc8);
        wait_for_pc(32'hf0);
        report_test();

        test_name    = "random_stall";
        stall_random = 1'b1;
        flush_to(32'h0);
        recording = 2;
        wait_for_pc(32'hf0);
        recording = 0;
        train(32'ha0, 1'b1);
        train(32'ha0, 1'b1);
        flush_to(32'h98);
        wait_for_pc(32'h80);
        wait_for_pc(32'hf0);
        flush_to(32'hc1);
        wait_for_pc(32'hc0);
        wait_for_pc(32'hf0);
        stall_random = 1'b0;
        if (stall_trace.size() != base_trace.size()) begin
            $display("Fail %s: trace length expected %0d actual %0d",
                     test_name, base_trace.size(), stall_trace.size());
            test_errors = test_errors + 1;
        end else begin
            for (int i = 0; i < base_trace.size(); i++) begin
                if (stall_trace[i] !== base_trace[i]) begin
                    $display("Fail %s: trace entry %0d expected %h actual %h",
                             test_name, i, base_trace[i], stall_trace[i]);
                    test_errors = test_errors + 1;
                end
            end
        end
        report_test();

        repeat (2) @(negedge clk);
        $display("%0d tests, %0d with mismatches, %0d bundles checked, %0d mismatches in total",
                 tests_run, tests_failed, bundle_count, total_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/front_pkg.sv
rtl/pc_gen.sv
rtl/inst_rom.sv
rtl/branch_decode.sv
rtl/bht.sv
rtl/bpu.sv
rtl/fetch_frontend.sv
sim/tb_fetch_frontend.sv

//--- prog.hex
// One 32-bit instruction word per line, from word address 0 upward
// Branches at 0x20 (B), 0x38 (BL), 0x50 and 0x5c (JIRL), 0x60, 0x88, 0xa8, 0xd0, 0xf0 (B), 0xa0 (BNE)
02800084
02800484
02800884
02800c84
02801084
02801484
02801884
02801c84
50001400
02802484
02802884
02802c84
02803084
02803484
54001800
02803c84
02804084
02804484
02804884
02804c84
4c000020
02805484
02805884
4c000020
50009000
02806484
02806884
02806c84
02807084
02807484
02807884
02807c84
02808084
02808484
50006800
02808c84
02809084
02809484
02809884
02809c84
5fffe085
0280a484
50004800
0280ac84
0280b084
0280b484
0280b884
0280bc84
0280c084
0280c484
0280c884
0280cc84
50002000
0280d484
0280d884
0280dc84
0280e084
0280e484
0280e884
0280ec84
50000000
0280f484
0280f884
0280fc84
